/* src/qla_pkg.sv */
// qla register map definitions
package qla_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int NUM_AXES = 4;        // motor axes on the board
    localparam int DATA_W   = 32;       // host register word
    localparam int ADDR_W   = 16;       // host register address
    localparam int CUR_W    = 16;       // adc and dac sample width
    localparam int SPACE_W  = 4;        // address space field
    localparam int CHAN_W   = 4;        // channel field
    localparam int OFF_W    = 4;        // offset field
    localparam int ID_W     = 4;        // rotary switch width

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CUR_W-1:0]  current_t;   // offset binary
    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [OFF_W-1:0]  off_t;

    // ------------------------------
    // address map
    // ------------------------------
    localparam int SPACE_LSB = 12;      // addr[15:12]
    localparam int CHAN_LSB  = 4;       // addr[7:4]
    localparam int OFF_LSB   = 0;       // addr[3:0]

    // only the main space survives here
    typedef enum logic [SPACE_W-1:0] {
        SPACE_MAIN = 4'd0
    } space_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // axis channel offsets
    localparam off_t OFF_ADC_DATA = 4'd0;   // latest current feedback
    localparam off_t OFF_DAC_CTRL = 4'd1;   // current command

    // board channel offsets
    localparam off_t OFF_STATUS   = 4'd0;

    // status word layout
    localparam int STAT_EN_LSB   = 0;   // effective amp enables
    localparam int STAT_MASK_LSB = 8;   // write mask for enables
    localparam int STAT_DIS_LSB  = 8;   // safety disables on read
    localparam int STAT_ID_LSB   = 24;  // board id

    // ------------------------------
    // safety constants
    // ------------------------------
    localparam current_t CURRENT_MID   = 16'h8000;  // zero current
    localparam current_t SAFETY_MARGIN = 16'h0100;  // slack on the limit

endpackage

/* src/bus_decode.sv */
// request decode stage
module bus_decode (
    input  logic             sysclk,
    input  logic             reset,

    // host request
    input  logic             req_valid,
    output logic             req_ready,
    input  qla_pkg::op_e     req_op,
    input  qla_pkg::addr_t   req_addr,
    input  qla_pkg::data_t   req_wdata,

    // from the return stage
    input  logic             s1_advance,

    // stage 1 contents
    output logic             s1_valid,
    output qla_pkg::op_e     s1_op,
    output qla_pkg::space_e  s1_space,
    output qla_pkg::chan_t   s1_chan,
    output qla_pkg::off_t    s1_offset,
    output qla_pkg::data_t   s1_wdata
);

    logic accept;   // request handshake this cycle

    // room when empty or when the held request leaves now
    assign req_ready = ~s1_valid | s1_advance;
    assign accept    = req_valid & req_ready;

    // ------------------------------
    // occupancy
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (req_ready) begin
            s1_valid <= req_valid;   // refill or drain
        end
    end

    // ------------------------------
    // request fields
    // ------------------------------
    // only loaded on a handshake, held otherwise
    always_ff @(posedge sysclk) begin
        if (accept) begin
            s1_op     <= req_op;
            s1_space  <= qla_pkg::space_e'(req_addr[qla_pkg::SPACE_LSB +: qla_pkg::SPACE_W]);
            s1_chan   <= req_addr[qla_pkg::CHAN_LSB +: qla_pkg::CHAN_W];   // 0 is board
            s1_offset <= req_addr[qla_pkg::OFF_LSB +: qla_pkg::OFF_W];
            s1_wdata  <= req_wdata;
        end
    end

    // addr[11:8] carries nothing in this map

endmodule

/* src/axis_regs.sv */
// per-axis command and feedback registers
module axis_regs (
    input  logic                                     sysclk,
    input  logic                                     reset,

    // stage 1 request
    input  logic                                     s1_advance,
    input  qla_pkg::op_e                             s1_op,
    input  qla_pkg::space_e                          s1_space,
    input  qla_pkg::chan_t                           s1_chan,
    input  qla_pkg::off_t                            s1_offset,
    input  qla_pkg::data_t                           s1_wdata,

    // adc feedback words
    input  logic                                     cur_fb_valid,
    input  qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] cur_fb,

    // dac commands and read value
    output qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] dac_cmd,
    output qla_pkg::data_t                           axis_rdata
);

    localparam int IDX_W = $clog2(qla_pkg::NUM_AXES);   // axis index bits
    localparam int PAD_W = qla_pkg::DATA_W - qla_pkg::CUR_W;

    qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] fb_latch;   // last feedback set
    logic                                     axis_hit;   // channel 1..NUM_AXES
    logic [IDX_W-1:0]                         axis_idx;   // channel minus one
    logic                                     cmd_wen;

    // ------------------------------
    // address decode
    // ------------------------------
    assign axis_hit = (s1_chan != '0) &&
                      (s1_chan <= qla_pkg::CHAN_W'(qla_pkg::NUM_AXES));
    assign axis_idx = IDX_W'(s1_chan - qla_pkg::chan_t'(1));

    // command write lands on the advance cycle
    assign cmd_wen = s1_advance &&
                     (s1_op == qla_pkg::OP_WRITE) &&
                     (s1_space == qla_pkg::SPACE_MAIN) &&
                     axis_hit &&
                     (s1_offset == qla_pkg::OFF_DAC_CTRL);

    // ------------------------------
    // dac command registers
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                dac_cmd[i] <= qla_pkg::CURRENT_MID;   // start at zero current
            end
        end else if (cmd_wen) begin
            dac_cmd[axis_idx] <= s1_wdata[qla_pkg::CUR_W-1:0];   // low half only
        end
    end

    // ------------------------------
    // feedback capture
    // ------------------------------
    // whole array latched on each strobe
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                fb_latch[i] <= qla_pkg::CURRENT_MID;
            end
        end else if (cur_fb_valid) begin
            fb_latch <= cur_fb;
        end
    end

    // ------------------------------
    // read value
    // ------------------------------
    // space and op filtering happen in the return stage
    always_comb begin
        axis_rdata = '0;   // unused channels and offsets
        if (axis_hit) begin
            case (s1_offset)
                qla_pkg::OFF_ADC_DATA: axis_rdata = {{PAD_W{1'b0}}, fb_latch[axis_idx]};
                qla_pkg::OFF_DAC_CTRL: axis_rdata = {{PAD_W{1'b0}}, dac_cmd[axis_idx]};
                default:               axis_rdata = '0;
            endcase
        end
    end

endmodule

/* src/board_regs.sv */
// board status and amplifier enables
module board_regs (
    input  logic                         sysclk,
    input  logic                         reset,

    // stage 1 request
    input  logic                         s1_advance,
    input  qla_pkg::op_e                 s1_op,
    input  qla_pkg::space_e              s1_space,
    input  qla_pkg::chan_t               s1_chan,
    input  qla_pkg::off_t                s1_offset,
    input  qla_pkg::data_t               s1_wdata,

    // board inputs
    input  logic [qla_pkg::ID_W-1:0]     wenid,            // rotary switch, active low
    input  logic [qla_pkg::NUM_AXES-1:0] safety_disable,   // from the safety checks

    output logic [qla_pkg::NUM_AXES-1:0] amp_enable,
    output logic [qla_pkg::NUM_AXES-1:0] clear_disable,    // one pulse per re-enable
    output qla_pkg::data_t               board_rdata
);

    logic [qla_pkg::NUM_AXES-1:0] amp_en_q;    // host requested enables
    logic [qla_pkg::NUM_AXES-1:0] wr_mask;     // which axes this write touches
    logic [qla_pkg::NUM_AXES-1:0] wr_en;       // new enable values
    logic [qla_pkg::ID_W-1:0]     board_id;
    logic                         status_sel;  // channel 0, status offset
    logic                         status_wen;
    qla_pkg::data_t               status_word;

    assign board_id = ~wenid;   // switch reads inverted

    // ------------------------------
    // status write decode
    // ------------------------------
    assign status_sel = (s1_chan == '0) && (s1_offset == qla_pkg::OFF_STATUS);
    assign status_wen = s1_advance &&
                        (s1_op == qla_pkg::OP_WRITE) &&
                        (s1_space == qla_pkg::SPACE_MAIN) &&
                        status_sel;

    assign wr_mask = s1_wdata[qla_pkg::STAT_MASK_LSB +: qla_pkg::NUM_AXES];
    assign wr_en   = s1_wdata[qla_pkg::STAT_EN_LSB +: qla_pkg::NUM_AXES];

    // masked write of 1 lets the safety latch go
    assign clear_disable = status_wen ? (wr_mask & wr_en) : '0;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            amp_en_q <= '0;   // amps off out of reset
        end else if (status_wen) begin
            amp_en_q <= (amp_en_q & ~wr_mask) | (wr_en & wr_mask);   // unmasked axes kept
        end
    end

    // safety disable always wins over the host
    assign amp_enable = amp_en_q & ~safety_disable;

    // ------------------------------
    // status read
    // ------------------------------
    always_comb begin
        status_word = '0;
        status_word[qla_pkg::STAT_EN_LSB +: qla_pkg::NUM_AXES]  = amp_enable;
        status_word[qla_pkg::STAT_DIS_LSB +: qla_pkg::NUM_AXES] = safety_disable;
        status_word[qla_pkg::STAT_ID_LSB +: qla_pkg::ID_W]      = board_id;
    end

    assign board_rdata = status_sel ? status_word : '0;   // other offsets read zero

endmodule

/* src/safety_check.sv */
// per-axis over-current check
module safety_check #(
    parameter int SAFETY_COUNT = 4   // consecutive bad samples before trip
) (
    input  logic              sysclk,
    input  logic              reset,
    input  logic              cur_fb_valid,         // new feedback sample
    input  qla_pkg::current_t cur_fb_axis,
    input  qla_pkg::current_t dac_cmd_axis,
    input  logic              clear_disable_axis,   // host re-enable
    output logic              safety_disable_axis
);

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);
    localparam int LIM_W = qla_pkg::CUR_W + 2;   // room for 2x plus margin

    qla_pkg::current_t fb_dist;    // |feedback - mid|
    qla_pkg::current_t cmd_dist;   // |command - mid|
    logic [LIM_W-1:0]  limit;
    logic              violation;
    logic [CNT_W-1:0]  bad_count;

    // ------------------------------
    // limit compare
    // ------------------------------
    assign fb_dist  = (cur_fb_axis >= qla_pkg::CURRENT_MID) ?
                      (cur_fb_axis - qla_pkg::CURRENT_MID) :
                      (qla_pkg::CURRENT_MID - cur_fb_axis);
    assign cmd_dist = (dac_cmd_axis >= qla_pkg::CURRENT_MID) ?
                      (dac_cmd_axis - qla_pkg::CURRENT_MID) :
                      (qla_pkg::CURRENT_MID - dac_cmd_axis);

    assign limit     = {1'b0, cmd_dist, 1'b0} + LIM_W'(qla_pkg::SAFETY_MARGIN);   // 2x + margin
    assign violation = LIM_W'(fb_dist) > limit;

    // ------------------------------
    // trip counter
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset || clear_disable_axis) begin
            bad_count           <= '0;
            safety_disable_axis <= 1'b0;
        end else if (cur_fb_valid) begin
            if (violation) begin
                if (bad_count != CNT_W'(SAFETY_COUNT)) begin
                    bad_count <= bad_count + 1'b1;   // saturates at the trip count
                end
                if (bad_count == CNT_W'(SAFETY_COUNT - 1)) begin
                    safety_disable_axis <= 1'b1;     // latched until cleared
                end
            end else begin
                bad_count <= '0;   // run broken
            end
        end
    end

endmodule

/* src/read_return.sv */
// response return stage
module read_return (
    input  logic            sysclk,
    input  logic            reset,

    // stage 1 request
    input  logic            s1_valid,
    input  qla_pkg::op_e    s1_op,
    input  qla_pkg::space_e s1_space,
    input  qla_pkg::chan_t  s1_chan,

    // read values from the register blocks
    input  qla_pkg::data_t  axis_rdata,
    input  qla_pkg::data_t  board_rdata,

    output logic            s1_advance,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output qla_pkg::data_t  rsp_rdata
);

    qla_pkg::data_t rdata_sel;

    // move on when the holding slot is free or draining now
    assign s1_advance = s1_valid & (~rsp_valid | rsp_ready);

    // writes and unmapped spaces answer zero
    always_comb begin
        if (s1_op == qla_pkg::OP_WRITE || s1_space != qla_pkg::SPACE_MAIN) begin
            rdata_sel = '0;
        end else begin
            rdata_sel = (s1_chan == '0) ? board_rdata : axis_rdata;   // chan 0 is board
        end
    end

    // ------------------------------
    // response slot
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (s1_advance) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;   // handshake done, nothing behind it
        end
    end

    always_ff @(posedge sysclk) begin
        if (s1_advance) begin
            rsp_rdata <= rdata_sel;   // held under back-pressure
        end
    end

endmodule

/* src/qla_top.sv */
// qla register pipeline top
module qla_top #(
    parameter int SAFETY_COUNT = 4
) (
    input  logic                                     sysclk,
    input  logic                                     reset,

    // host request
    input  logic                                     req_valid,
    output logic                                     req_ready,
    input  qla_pkg::op_e                             req_op,
    input  qla_pkg::addr_t                           req_addr,
    input  qla_pkg::data_t                           req_wdata,

    // response
    output logic                                     rsp_valid,
    input  logic                                     rsp_ready,
    output qla_pkg::data_t                           rsp_rdata,

    // board I/Os
    input  logic [qla_pkg::ID_W-1:0]                 wenid,          // rotary switch
    input  logic                                     cur_fb_valid,
    input  qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] cur_fb,         // from adcs
    output qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] dac_cmd,        // to dacs
    output logic [qla_pkg::NUM_AXES-1:0]             amp_enable
);

    // ------------------------------
    // stage 1 wires
    // ------------------------------
    logic            s1_valid;
    logic            s1_advance;
    qla_pkg::op_e    s1_op;
    qla_pkg::space_e s1_space;
    qla_pkg::chan_t  s1_chan;
    qla_pkg::off_t   s1_offset;
    qla_pkg::data_t  s1_wdata;

    qla_pkg::data_t  axis_rdata;
    qla_pkg::data_t  board_rdata;

    logic [qla_pkg::NUM_AXES-1:0] safety_disable;   // safety checks to board regs
    logic [qla_pkg::NUM_AXES-1:0] clear_disable;    // board regs to safety checks

    bus_decode u_decode (
        .sysclk(sysclk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_addr(req_addr), .req_wdata(req_wdata), .s1_advance(s1_advance),
        .s1_valid(s1_valid), .s1_op(s1_op), .s1_space(s1_space),
        .s1_chan(s1_chan), .s1_offset(s1_offset), .s1_wdata(s1_wdata)
    );

    axis_regs u_axis (
        .sysclk(sysclk), .reset(reset), .s1_advance(s1_advance),
        .s1_op(s1_op), .s1_space(s1_space), .s1_chan(s1_chan),
        .s1_offset(s1_offset), .s1_wdata(s1_wdata),
        .cur_fb_valid(cur_fb_valid), .cur_fb(cur_fb),
        .dac_cmd(dac_cmd), .axis_rdata(axis_rdata)
    );

    board_regs u_board (
        .sysclk(sysclk), .reset(reset), .s1_advance(s1_advance),
        .s1_op(s1_op), .s1_space(s1_space), .s1_chan(s1_chan),
        .s1_offset(s1_offset), .s1_wdata(s1_wdata), .wenid(wenid),
        .safety_disable(safety_disable), .amp_enable(amp_enable),
        .clear_disable(clear_disable), .board_rdata(board_rdata)
    );

    read_return u_return (
        .sysclk(sysclk), .reset(reset), .s1_valid(s1_valid),
        .s1_op(s1_op), .s1_space(s1_space), .s1_chan(s1_chan),
        .axis_rdata(axis_rdata), .board_rdata(board_rdata),
        .s1_advance(s1_advance), .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata)
    );

    // one over-current check per axis
    for (genvar i = 0; i < qla_pkg::NUM_AXES; i++) begin : g_safety
        safety_check #(.SAFETY_COUNT(SAFETY_COUNT)) u_safe (
            .sysclk(sysclk), .reset(reset), .cur_fb_valid(cur_fb_valid),
            .cur_fb_axis(cur_fb[i]), .dac_cmd_axis(dac_cmd[i]),
            .clear_disable_axis(clear_disable[i]),
            .safety_disable_axis(safety_disable[i])
        );
    end

endmodule

/* verification/tb_qla_top.sv */
// qla register pipeline testbench
module tb_qla_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SAFETY_COUNT = 4;    // dut default
    localparam int TIMEOUT      = 20;   // cycles allowed per wait
    localparam qla_pkg::current_t MID = qla_pkg::CURRENT_MID;
    localparam qla_pkg::op_e RD = qla_pkg::OP_READ;
    localparam qla_pkg::op_e WR = qla_pkg::OP_WRITE;

    typedef struct {
        qla_pkg::op_e      op;
        qla_pkg::addr_t    addr;
        qla_pkg::data_t    wdata;
        qla_pkg::data_t    exp;       // expected response word
        int                fb_n;      // feedback strobes before the request
        qla_pkg::current_t fb_val;    // axis 2 feedback on those strobes
        bit                amp_chk;
        logic [3:0]        amp_exp;
    } entry_t;

    logic                                      sysclk;
    logic                                      reset;
    logic                                      req_valid;
    logic                                      req_ready;
    qla_pkg::op_e                              req_op;
    qla_pkg::addr_t                            req_addr;
    qla_pkg::data_t                            req_wdata;
    logic                                      rsp_valid;
    logic                                      rsp_ready;
    qla_pkg::data_t                            rsp_rdata;
    logic [3:0]                                wenid;
    logic                                      cur_fb_valid;
    qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] cur_fb;
    qla_pkg::current_t [qla_pkg::NUM_AXES-1:0] dac_cmd;
    logic [qla_pkg::NUM_AXES-1:0]              amp_enable;

    entry_t         table_q[$];
    qla_pkg::data_t cmd_val[qla_pkg::NUM_AXES];   // random commands per axis
    logic [31:0]    lfsr = 32'h750b9acd;
    int             mismatches = 0;
    int             timeouts = 0;

    qla_top dut0 (
        .sysclk(sysclk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req_op(req_op),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
        .wenid(wenid), .cur_fb_valid(cur_fb_valid), .cur_fb(cur_fb),
        .dac_cmd(dac_cmd), .amp_enable(amp_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // ------------------------------
    // helpers
    // ------------------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output qla_pkg::data_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // status layout: id 27:24, disables 11:8, enables 3:0
    function automatic qla_pkg::data_t status_exp(logic [3:0] en, logic [3:0] dis);
        return {4'h0, 4'd5, 12'h000, dis, 4'h0, en};
    endfunction

    function automatic void add_entry(qla_pkg::op_e op, qla_pkg::addr_t addr,
                                      qla_pkg::data_t wdata, qla_pkg::data_t exp,
                                      int fb_n, qla_pkg::current_t fb_val,
                                      bit amp_chk, logic [3:0] amp_exp);
        entry_t e;
        e = '{op, addr, wdata, exp, fb_n, fb_val, amp_chk, amp_exp};
        table_q.push_back(e);
    endfunction

    task automatic check_word(input string what, input qla_pkg::data_t got,
                              input qla_pkg::data_t exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic pulse_feedback(input int n, input qla_pkg::current_t val);
        for (int i = 0; i < n; i++) begin
            cur_fb = {qla_pkg::NUM_AXES{MID}};
            cur_fb[1] = val;   // axis 2 only
            cur_fb_valid = 1'b1;
            @(negedge sysclk);
        end
        cur_fb_valid = 1'b0;
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic offer_req(input entry_t e, input int max_cycles, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        req_valid = 1'b1;
        req_op    = e.op;
        req_addr  = e.addr;
        req_wdata = e.wdata;
        while (!ok && n < max_cycles) begin
            #1;
            if (req_ready) ok = 1'b1;   // transfer on the next rising edge
            @(negedge sysclk);
            n++;
        end
    endtask

    task automatic wait_rsp(output qla_pkg::data_t data, output bit ok);
        int n;
        ok = 1'b0;
        n = 0;
        data = '0;
        while (!ok && n < TIMEOUT) begin
            #1;
            if (rsp_valid && rsp_ready) begin
                data = rsp_rdata;
                ok = 1'b1;
            end
            @(negedge sysclk);
            n++;
        end
        if (!ok) begin
            timeouts++;
            $display("timeout: no response arrived within %0d cycles", TIMEOUT);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        entry_t         e;
        entry_t         bp[3];
        qla_pkg::data_t w;
        qla_pkg::data_t got;
        bit             ok;
        bit             ok_c;
        bit             got_ok;
        int             accepted;
        int             chan;

        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = RD;
        req_addr     = '0;
        req_wdata    = '0;
        rsp_ready    = 1'b1;
        wenid        = 4'b1010;   // board id 5
        cur_fb_valid = 1'b0;
        cur_fb       = {qla_pkg::NUM_AXES{MID}};
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        check_word("req_ready after reset", req_ready, 1);
        check_word("rsp_valid after reset", rsp_valid, 0);
        check_word("amp_enable after reset", amp_enable, 0);
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            check_word($sformatf("dac_cmd[%0d] after reset", i), dac_cmd[i], MID);
        end

        // board id, unused offsets, channels and spaces
        add_entry(RD, 16'h0000, 0, status_exp(4'h0, 4'h0), 0, MID, 1, 4'h0);
        add_entry(RD, 16'h0003, 0, 0, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h0020, 0, 32'h0000_7f00, 1, 16'h7f00, 0, 4'h0);
        add_entry(RD, 16'h0010, 0, 32'h0000_8000, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h0012, 0, 0, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h0051, 0, 0, 0, MID, 0, 4'h0);   // channel 5
        add_entry(RD, 16'h00f1, 0, 0, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h1000, 0, 0, 0, MID, 0, 4'h0);   // unmapped space
        add_entry(WR, 16'h3021, 32'h0000_1234, 0, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h0021, 0, 32'h0000_8000, 0, MID, 0, 4'h0);   // untouched

        // command write and readback per axis
        for (int c = 1; c <= qla_pkg::NUM_AXES; c++) begin
            rand_word(w);
            cmd_val[c-1] = w;
            add_entry(WR, {8'h00, 4'(c), 4'h1}, w, 0, 0, MID, 0, 4'h0);
            add_entry(RD, {8'h00, 4'(c), 4'h1}, 0, {16'h0, w[15:0]}, 0, MID, 0, 4'h0);
        end

        // masked amplifier enables
        add_entry(WR, 16'h0000, 32'h0000_050f, 0, 0, MID, 1, 4'b0101);
        add_entry(RD, 16'h0000, 0, status_exp(4'b0101, 4'h0), 0, MID, 1, 4'b0101);
        add_entry(WR, 16'h0000, 32'h0000_0302, 0, 0, MID, 1, 4'b0110);
        add_entry(RD, 16'h0000, 0, status_exp(4'b0110, 4'h0), 0, MID, 1, 4'b0110);
        add_entry(WR, 16'h0000, 32'h0000_0f0f, 0, 0, MID, 1, 4'b1111);
        add_entry(RD, 16'h0000, 0, status_exp(4'hf, 4'h0), 0, MID, 1, 4'b1111);

        // over-current on axis 2, allowed distance 0x300
        add_entry(WR, 16'h0021, 32'h0000_8100, 0, 0, MID, 0, 4'h0);
        add_entry(RD, 16'h0000, 0, status_exp(4'hf, 4'h0), SAFETY_COUNT - 1, 16'h8400,
                  1, 4'hf);
        add_entry(RD, 16'h0000, 0, status_exp(4'hf, 4'h0), 1, 16'h8300, 1, 4'hf);
        // still short of the trip here, the compliant strobe restarted the count
        add_entry(RD, 16'h0000, 0, status_exp(4'hf, 4'h0), SAFETY_COUNT - 1, 16'h8400,
                  1, 4'hf);
        add_entry(RD, 16'h0000, 0, status_exp(4'b1101, 4'b0010), 1, 16'h8400,
                  1, 4'b1101);
        add_entry(RD, 16'h0020, 0, 32'h0000_8400, 0, MID, 1, 4'b1101);
        add_entry(WR, 16'h0000, 32'h0000_0202, 0, 0, MID, 1, 4'hf);   // re-enable axis 2
        add_entry(RD, 16'h0000, 0, status_exp(4'hf, 4'h0), 0, MID, 1, 4'hf);

        for (int k = 0; k < table_q.size(); k++) begin
            e = table_q[k];
            pulse_feedback(e.fb_n, e.fb_val);
            offer_req(e, TIMEOUT, ok);
            req_valid = 1'b0;
            if (!ok) begin
                timeouts++;
                $display("timeout: request %0d at address %h was never accepted", k, e.addr);
            end else begin
                wait_rsp(got, got_ok);
                if (got_ok) check_word($sformatf("entry %0d addr %h", k, e.addr), got, e.exp);
                chan = e.addr[7:4];
                if (e.op == WR && e.addr[15:12] == 0 && e.addr[3:0] == 1 &&
                    chan >= 1 && chan <= qla_pkg::NUM_AXES) begin
                    check_word($sformatf("dac_cmd[%0d]", chan - 1), dac_cmd[chan-1],
                               e.wdata[15:0]);
                end
                if (e.amp_chk) check_word($sformatf("amp_enable entry %0d", k),
                                          amp_enable, e.amp_exp);
            end
        end

        // ------------------------------
        // back-pressure
        // ------------------------------
        bp[0] = '{RD, 16'h0000, 0, status_exp(4'hf, 4'h0), 0, MID, 0, 4'h0};
        bp[1] = '{RD, 16'h0011, 0, {16'h0, cmd_val[0][15:0]}, 0, MID, 0, 4'h0};
        bp[2] = '{RD, 16'h0020, 0, 32'h0000_8400, 0, MID, 0, 4'h0};
        rsp_ready = 1'b0;
        accepted = 0;
        offer_req(bp[0], TIMEOUT, ok);
        accepted += ok;
        offer_req(bp[1], TIMEOUT, ok);
        accepted += ok;
        offer_req(bp[2], 6, ok);   // third should stall, both stages full
        accepted += ok;
        check_word("requests accepted under back-pressure", accepted, 2);

        rsp_ready = 1'b1;
        fork
            begin
                if (accepted < 3) offer_req(bp[2], TIMEOUT, ok_c);
                else ok_c = 1'b1;
                req_valid = 1'b0;
                if (!ok_c) begin
                    timeouts++;
                    $display("timeout: third request was never accepted after release");
                end
            end
            begin
                for (int k = 0; k < 3; k++) begin
                    wait_rsp(got, got_ok);
                    if (got_ok) check_word($sformatf("back-pressure response %0d", k),
                                           got, bp[k].exp);
                end
            end
        join

        // one response per request, nothing left behind
        check_word("rsp_valid after the last response", rsp_valid, 0);

        $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim.f */
src/qla_pkg.sv
src/bus_decode.sv
src/axis_regs.sv
src/board_regs.sv
src/safety_check.sv
src/read_return.sv
src/qla_top.sv
verification/tb_qla_top.sv
